// ==== dv/npc_ref_model.svh ====
`ifndef NPC_REF_MODEL_SVH
`define NPC_REF_MODEL_SVH

// architectural state of the model
logic [31:0] m_regs [0:31];
logic [31:0] m_pc;
logic        m_halted;
// 64-word data window, indexed by address bits 7:2
logic [31:0] m_mem [0:63];

// executes one instruction and reports the writes it makes
task automatic model_step(
    input  logic [31:0] inst,
    output logic        wen,
    output logic [4:0]  waddr,
    output logic [31:0] wdata,
    output logic        st,
    output logic [31:0] saddr,
    output logic [31:0] sdata
);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] ea;
    logic [31:0] word;
    logic [31:0] npc;
    begin
        f3    = inst[14:12];
        a     = m_regs[inst[19:15]];
        b     = m_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_u = {inst[31:12], 12'h000};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        wen   = 1'b0;
        waddr = inst[11:7];
        wdata = '0;
        st    = 1'b0;
        saddr = '0;
        sdata = '0;
        npc   = m_pc + 4;
        case (inst[6:0])
            op_lui: begin
                wen   = 1'b1;
                wdata = imm_u;
            end
            op_auipc: begin
                wen   = 1'b1;
                wdata = m_pc + imm_u;
            end
            op_jal: begin
                wen   = 1'b1;
                wdata = m_pc + 4;
                npc   = m_pc + imm_j;
            end
            op_jalr: if (f3 == f3_add) begin
                wen   = 1'b1;
                wdata = m_pc + 4;
                npc   = (a + imm_i) & ~32'h1;
            end
            op_imm: if (f3 == f3_add) begin
                wen   = 1'b1;
                wdata = a + imm_i;
            end
            op_reg: if (f3 == f3_add) begin
                wen   = 1'b1;
                wdata = a + b;
            end
            op_load: begin
                ea   = a + imm_i;
                word = m_mem[ea[7:2]];
                if (f3 == f3_word) begin
                    wen   = 1'b1;
                    wdata = word;
                end else if (f3 == f3_byte_u) begin
                    wen   = 1'b1;
                    wdata = (word >> (8 * ea[1:0])) & 32'hff;
                end
            end
            op_store: if (f3 == f3_word) begin
                st    = 1'b1;
                saddr = a + imm_s;
                sdata = b;
            end
            op_system: if (inst == ebreak_word) begin
                m_halted = 1'b1;
                npc      = m_pc;
            end
            default: ;
        endcase
        // x0 is never written
        if (waddr == 5'd0) wen = 1'b0;
        if (wen) m_regs[waddr] = wdata;
        if (st) m_mem[saddr[7:2]] = sdata;
        m_pc = npc;
    end
endtask

`endif

// ==== dv/npc_tb.sv ====
`timescale 1ns/10ps

module npc_tb
    import rv_isa_pkg::*;
    import npc_cfg_pkg::*;
;

    logic        clk;
    logic        reset;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_rdata;
    logic [31:0] dmem_wdata;
    logic        dmem_wen;
    logic        rf_wen;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic        halted;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] lfsr_state;
    int          prog_len;
    bit          gen_done;
    int          mismatches;
    int          other_errors;

    `include "npc_ref_model.svh"

    npc_top UUT (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .pc         (pc),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .rf_wen     (rf_wen),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .halted     (halted)
    );

    // combinational memories, program sits at the reset vector
    assign inst       = imem[pc[9:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_wen) dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    endtask

    // builds the random program, x8 is the data base, x9 the jalr base
    task automatic build_program();
        logic [31:0] rv;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [7:0]  off;
        int          kind;
        prog_len = 0;
        for (int r = 1; r < 8; r++) emit({20'(rand_bits(20)), r[4:0], op_lui});
        emit({20'h00002, 5'd8, op_lui});
        while (prog_len < 208) begin
            kind = rand_bits(4) % 9;
            rd   = 5'(rand_bits(3));
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            rv   = rand_bits(20);
            case (kind)
                0: emit({rv[19:0], rd, op_lui});
                1: emit({rv[19:0], rd, op_auipc});
                // jal +4
                2: emit({1'b0, 10'd2, 1'b0, 8'd0, rd, op_jal});
                3: emit({rv[11:0], rs1, f3_add, rd, op_imm});
                4: emit({7'd0, rs2, rs1, f3_add, rd, op_reg});
                5: emit({4'd0, rv[5:0], 2'b00, 5'd8, f3_word, rd, op_load});
                6: emit({4'd0, rv[7:0], 5'd8, f3_byte_u, rd, op_load});
                7: begin
                    off = {rv[5:0], 2'b00};
                    emit({4'd0, off[7:5], rs2, 5'd8, f3_word, off[4:0], op_store});
                end
                default: begin
                    // odd offset 9 checks that bit 0 is cleared
                    if (prog_len < 207) begin
                        emit({20'd0, 5'd9, op_auipc});
                        emit({12'd9, 5'd9, f3_add, rd, op_jalr});
                    end
                end
            endcase
        end
        emit(ebreak_word);
    endtask

    initial begin : watchdog
        wait (gen_done);
        repeat (prog_len + 20) @(posedge clk);
        other_errors++;
        $display("error: watchdog expired before the core halted");
        print_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        logic        e_wen;
        logic [4:0]  e_waddr;
        logic [31:0] e_wdata;
        logic        e_st;
        logic [31:0] e_saddr;
        logic [31:0] e_sdata;
        reset        = 1'b1;
        gen_done     = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        lfsr_state   = 32'h3fd3_70d3;
        build_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i]   = rand_bits(32);
            m_mem[i]  = dmem[i];
        end
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        m_pc     = default_reset_vector;
        m_halted = 1'b0;
        gen_done = 1'b1;

        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        // first cycle after reset stays idle
        @(negedge clk);
        check_word("pc", pc, 32'h8000_0000);
        check_word("rf_wen", rf_wen, 0);
        check_word("dmem_wen", dmem_wen, 0);
        check_word("halted", halted, 0);

        while (!m_halted) begin
            @(negedge clk);
            check_word("pc", pc, m_pc);
            check_word("halted", halted, 0);
            model_step(imem[m_pc[9:2]], e_wen, e_waddr, e_wdata, e_st, e_saddr, e_sdata);
            check_word("rf_wen", rf_wen, e_wen);
            if (e_wen) begin
                check_word("rf_waddr", rf_waddr, e_waddr);
                check_word("rf_wdata", rf_wdata, e_wdata);
            end
            check_word("dmem_wen", dmem_wen, e_st);
            if (e_st) begin
                check_word("dmem_addr", dmem_addr, e_saddr);
                check_word("dmem_wdata", dmem_wdata, e_sdata);
            end
        end

        // parked on the ebreak
        repeat (10) begin
            @(negedge clk);
            check_word("halted", halted, 1);
            check_word("pc", pc, m_pc);
            check_word("rf_wen", rf_wen, 0);
            check_word("dmem_wen", dmem_wen, 0);
        end

        for (int i = 0; i < 64; i++) check_word($sformatf("dmem[%0d]", i), dmem[i], m_mem[i]);

        print_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu
    import rv_isa_pkg::*;
    import npc_cfg_pkg::*;
(
    input  logic [alu_op_w-1:0] alu_op,
    input  logic [xlen-1:0]     pc,
    input  logic [xlen-1:0]     imm,
    input  logic [xlen-1:0]     src1,
    input  logic [xlen-1:0]     src2,
    output logic [xlen-1:0]     result
);

    logic [xlen-1:0] pc_link;

    // return address for jal and jalr
    assign pc_link = pc + 32'd4;

    always_comb begin
        result = '0;
        if (alu_op[aop_auipc]) begin
            result = pc + imm;
        end else if (alu_op[aop_lui]) begin
            result = imm;
        end else if (alu_op[aop_jal] || alu_op[aop_jalr]) begin
            result = pc_link;
        end else if (alu_op[aop_addi]) begin
            result = src1 + imm;
        end else if (alu_op[aop_add]) begin
            result = src1 + src2;
        end
        // loads and stores go through the lsu
    end

endmodule

// ==== src/commit_unit.sv ====
`timescale 1ns/10ps

module commit_unit
    import npc_cfg_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = default_reset_vector
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            is_jal,
    input  logic            is_jalr,
    input  logic            is_load,
    input  logic            is_ebreak,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] load_data,
    output logic [xlen-1:0] pc,
    output logic            running,
    output logic            halted,
    output logic [xlen-1:0] wb_data
);

    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] jalr_target;

    // write-back source
    assign wb_data = is_load ? load_data : alu_result;

    assign jalr_target = src1 + imm;

    // strobes are already low when not running
    always_comb begin
        if (is_jal) begin
            next_pc = pc + imm;
        end else if (is_jalr) begin
            next_pc = {jalr_target[xlen-1:1], 1'b0};
        end else if (running && !is_ebreak) begin
            next_pc = pc + 32'd4;
        end else begin
            // idle, or parked on the ebreak
            next_pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= reset_vector;
            running <= 1'b0;
            halted  <= 1'b0;
        end else begin
            pc <= next_pc;
            if (is_ebreak) begin
                running <= 1'b0;
                halted  <= 1'b1;
            end else if (!halted) begin
                // first cycle out of reset only arms this
                running <= 1'b1;
            end
        end
    end

endmodule

// ==== src/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder
    import rv_isa_pkg::*;
    import npc_cfg_pkg::*;
(
    input  logic [xlen-1:0]       inst,
    input  logic                  running,
    output logic [xlen-1:0]       imm,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output logic [alu_op_w-1:0]   alu_op,
    output logic                  reg_wen,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_jal,
    output logic                  is_jalr,
    output logic                  is_ebreak
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            fmt_i;
    logic            fmt_s;
    logic            fmt_u;
    logic            fmt_j;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [alu_op_w-1:0] op_raw;
    logic            writes_rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // format classes by opcode
    assign fmt_i = (opcode == op_imm) || (opcode == op_load) || (opcode == op_jalr);
    assign fmt_s = (opcode == op_store);
    assign fmt_u = (opcode == op_lui) || (opcode == op_auipc);
    assign fmt_j = (opcode == op_jal);

    // all immediates sign-extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // R type and system carry no immediate
    assign imm = ({xlen{fmt_i}} & imm_i)
               | ({xlen{fmt_s}} & imm_s)
               | ({xlen{fmt_u}} & imm_u)
               | ({xlen{fmt_j}} & imm_j);

    // per-instruction decode before qualification
    assign op_raw[aop_auipc] = (opcode == op_auipc);
    assign op_raw[aop_lui]   = (opcode == op_lui);
    assign op_raw[aop_jal]   = (opcode == op_jal);
    assign op_raw[aop_jalr]  = (opcode == op_jalr) && (funct3 == f3_add);
    assign op_raw[aop_addi]  = (opcode == op_imm) && (funct3 == f3_add);
    assign op_raw[aop_add]   = (opcode == op_reg) && (funct3 == f3_add);
    assign op_raw[aop_lw]    = (opcode == op_load) && (funct3 == f3_word);
    assign op_raw[aop_lbu]   = (opcode == op_load) && (funct3 == f3_byte_u);
    assign op_raw[aop_sw]    = (opcode == op_store) && (funct3 == f3_word);

    // nothing retires while the core is idle or halted
    assign alu_op = running ? op_raw : '0;

    // every op except sw writes rd
    assign writes_rd = |op_raw[aop_lbu:aop_auipc];

    assign reg_wen   = running && writes_rd && (rd != '0);
    assign is_load   = running && (op_raw[aop_lw] || op_raw[aop_lbu]);
    assign is_store  = running && op_raw[aop_sw];
    assign is_jal    = running && op_raw[aop_jal];
    assign is_jalr   = running && op_raw[aop_jalr];
    assign is_ebreak = running && (inst == ebreak_word);

endmodule

// ==== src/lsu.sv ====
`timescale 1ns/10ps

module lsu
    import npc_cfg_pkg::*;
(
    input  logic            is_load,
    input  logic            is_store,
    input  logic            lbu,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] dmem_rdata,
    output logic [xlen-1:0] dmem_addr,
    output logic [xlen-1:0] dmem_wdata,
    output logic            dmem_wen,
    output logic [xlen-1:0] load_data
);

    logic [7:0] byte_lane;

    // base plus offset, same for lw, lbu and sw
    assign dmem_addr = src1 + imm;

    // memory returns the aligned word, pick the lane
    always_comb begin
        case (dmem_addr[1:0])
            2'd0:    byte_lane = dmem_rdata[7:0];
            2'd1:    byte_lane = dmem_rdata[15:8];
            2'd2:    byte_lane = dmem_rdata[23:16];
            default: byte_lane = dmem_rdata[31:24];
        endcase
    end

    always_comb begin
        if (!is_load) begin
            load_data = '0;
        end else if (lbu) begin
            load_data = {{(xlen-8){1'b0}}, byte_lane};
        end else begin
            load_data = dmem_rdata;
        end
    end

    // word store only
    assign dmem_wdata = src2;
    assign dmem_wen   = is_store;

endmodule

// ==== src/npc_cfg_pkg.sv ====
package npc_cfg_pkg;

    // machine word width
    localparam int xlen = 32;

    // register index width, 32 registers
    localparam int reg_addr_w = 5;

    // first fetch address after reset
    localparam logic [xlen-1:0] default_reset_vector = 32'h8000_0000;

endpackage

// ==== src/npc_top.sv ====
`timescale 1ns/10ps

module npc_top
    import rv_isa_pkg::*;
    import npc_cfg_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = default_reset_vector
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       inst,
    output logic [xlen-1:0]       pc,
    output logic [xlen-1:0]       dmem_addr,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic [xlen-1:0]       dmem_wdata,
    output logic                  dmem_wen,
    output logic                  rf_wen,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic                  halted
);

    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [alu_op_w-1:0]   alu_op;
    logic                  reg_wen;
    logic                  is_load;
    logic                  is_store;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_ebreak;
    logic                  running;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       load_data;
    logic [xlen-1:0]       wb_data;

    inst_decoder u_decoder (
        .inst      (inst),
        .running   (running),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .alu_op    (alu_op),
        .reg_wen   (reg_wen),
        .is_load   (is_load),
        .is_store  (is_store),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .is_ebreak (is_ebreak)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .wen    (reg_wen),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (wb_data),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    alu u_alu (
        .alu_op (alu_op),
        .pc     (pc),
        .imm    (imm),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    lsu u_lsu (
        .is_load    (is_load),
        .is_store   (is_store),
        .lbu        (alu_op[aop_lbu]),
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .load_data  (load_data)
    );

    commit_unit #(
        .reset_vector (reset_vector)
    ) u_commit (
        .clk        (clk),
        .reset      (reset),
        .is_jal     (is_jal),
        .is_jalr    (is_jalr),
        .is_load    (is_load),
        .is_ebreak  (is_ebreak),
        .imm        (imm),
        .src1       (src1),
        .alu_result (alu_result),
        .load_data  (load_data),
        .pc         (pc),
        .running    (running),
        .halted     (halted),
        .wb_data    (wb_data)
    );

    // trace mirrors the register-file write port
    assign rf_wen   = reg_wen;
    assign rf_waddr = rd;
    assign rf_wdata = wb_data;

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/10ps

module reg_file
    import npc_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  wen,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [0:(1 << reg_addr_w)-1];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 values
    // jalr, addi and add share f3_add
    localparam logic [2:0] f3_add    = 3'b000;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;

    // full encoding, no operand fields
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    // one-hot operation vector
    localparam int alu_op_w = 9;

    // bit positions in alu_op
    localparam int aop_auipc = 0;
    localparam int aop_lui   = 1;
    localparam int aop_jal   = 2;
    localparam int aop_jalr  = 3;
    localparam int aop_addi  = 4;
    localparam int aop_add   = 5;
    localparam int aop_lw    = 6;
    localparam int aop_lbu   = 7;
    localparam int aop_sw    = 8;

endpackage

// ==== verilog.f ====
+incdir+dv
src/rv_isa_pkg.sv
src/npc_cfg_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/alu.sv
src/lsu.sv
src/commit_unit.sv
src/npc_top.sv
dv/npc_tb.sv
